//--- hw/aa_pkg.sv
// aa bridge shared definitions
// bus widths, stream cycle codes, address window decode and the
// beat and register write structs passed between the two engines
package aa_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int DATA_W  = 32;
  localparam int STRB_W  = 4;
  // local axi-lite address
  localparam int LADDR_W = 15;
  // address field carried in a stream beat
  localparam int RADDR_W = 28;
  localparam int USER_W  = 2;

  // --------------------------------------------------
  // stream cycle type, carried on tuser
  // --------------------------------------------------
  localparam logic [USER_W-1:0] TUSER_STREAM   = 2'b00;
  localparam logic [USER_W-1:0] TUSER_WRITE    = 2'b01;
  localparam logic [USER_W-1:0] TUSER_READ_REQ = 2'b10;
  localparam logic [USER_W-1:0] TUSER_READ_CPL = 2'b11;

  // --------------------------------------------------
  // window decode
  // --------------------------------------------------
  // local address bits 14:12
  localparam logic [2:0]  LOCAL_WIN        = 3'b010;
  // local page, address bits 11:8
  localparam logic [3:0]  LOCAL_REG_PAGE   = 4'h1;
  localparam logic [3:0]  LOCAL_MBOX_PAGE  = 4'h0;
  // remote page, beat address bits 27:8
  localparam logic [19:0] REMOTE_REG_PAGE  = 20'h00021;
  localparam logic [19:0] REMOTE_MBOX_PAGE = 20'h00020;

  // --------------------------------------------------
  // mailbox and interrupt registers
  // --------------------------------------------------
  localparam int MBOX_WORDS   = 8;
  localparam int MBOX_IDX_W   = 3;
  // word index sits at address bits 4:2
  localparam int MBOX_IDX_LSB = 2;
  // 0 selects enable, 1 selects status
  localparam int REG_SEL_BIT  = 2;

  // one stream beat, same layout in both directions
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [USER_W-1:0] user;
  } stream_beat_t;

  // register file write request
  // reg_sel high targets the interrupt registers, low the mailbox
  typedef struct packed {
    logic                  valid;
    logic [MBOX_IDX_W-1:0] idx;
    logic                  reg_sel;
    logic [DATA_W-1:0]     data;
    logic [STRB_W-1:0]     strb;
  } reg_wr_t;

endpackage

//--- hw/aa_mailbox_regs.sv
`timescale 1ns/1ps
// aa mailbox and interrupt registers
// eight strobed mailbox words, interrupt enable and status
// a remote mailbox write sets status, local write-one clears it
// irq is status and enable, read mux serves the local engine
module aa_mailbox_regs
  import aa_pkg::*;
(
  input  logic               axis_clk,
  input  logic               axis_rst_n,
  input  reg_wr_t            lcl_wr,
  input  reg_wr_t            rmt_wr,
  input  logic [LADDR_W-1:0] lcl_rd_addr,
  output logic [DATA_W-1:0]  lcl_rd_data,
  output logic               mb_irq
);

  logic [DATA_W-1:0] mbox [MBOX_WORDS];
  logic              intr_enable;
  logic              intr_status;
  reg_wr_t           wr;
  logic              sts_clr;
  logic              sts_set;
  logic              rd_reg;

  // engines never write in the same cycle, local side first anyway
  assign wr = lcl_wr.valid ? lcl_wr : rmt_wr;

  // --------------------------------------------------
  // mailbox words
  // --------------------------------------------------
  always_ff @(posedge axis_clk) begin
    if (wr.valid && !wr.reg_sel) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr.strb[b]) begin
          mbox[wr.idx][8*b +: 8] <= wr.data[8*b +: 8];
        end
      end
    end
  end

  // --------------------------------------------------
  // interrupt enable and status
  // --------------------------------------------------
  // status only clears from the local side
  assign sts_clr = lcl_wr.valid && lcl_wr.reg_sel &&
                   lcl_wr.idx[REG_SEL_BIT - MBOX_IDX_LSB] &&
                   lcl_wr.strb[0] && lcl_wr.data[0];
  // any remote mailbox write with a strobe set
  assign sts_set = rmt_wr.valid && !rmt_wr.reg_sel && (|rmt_wr.strb);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      if (wr.valid && wr.reg_sel && !wr.idx[REG_SEL_BIT - MBOX_IDX_LSB] && wr.strb[0]) begin
        intr_enable <= wr.data[0];
      end
      // clear beats set
      if (sts_clr) begin
        intr_status <= 1'b0;
      end else if (sts_set) begin
        intr_status <= 1'b1;
      end
    end
  end

  assign mb_irq = intr_status && intr_enable;

  // read mux, local engine only uses it on a window hit
  assign rd_reg      = (lcl_rd_addr[11:8] == LOCAL_REG_PAGE);
  assign lcl_rd_data = rd_reg ?
      {{(DATA_W-1){1'b0}}, lcl_rd_addr[REG_SEL_BIT] ? intr_status : intr_enable} :
      mbox[lcl_rd_addr[MBOX_IDX_LSB +: MBOX_IDX_W]];

endmodule

//--- hw/aa_remote_engine.sv
`timescale 1ns/1ps
// aa remote engine
// stream slave side of the bridge: collects two-beat writes into the
// register window and captures read completions for the local engine
// plain beats, read requests and writes outside the window are dropped
module aa_remote_engine
  import aa_pkg::*;
(
  input  logic              axis_clk,
  input  logic              axis_rst_n,
  input  stream_beat_t      rx_beat,
  input  logic              rx_valid,
  output logic              rx_ready,
  input  logic              local_busy,
  input  logic              cpl_wait,
  output reg_wr_t           rmt_wr,
  output logic              remote_busy,
  output logic              cpl_valid,
  output logic [DATA_W-1:0] cpl_data
);

  typedef enum logic [1:0] {
    st_idle,
    st_beat2,
    st_commit
  } state_t;

  state_t             state;
  logic [RADDR_W-1:0] addr_q;
  logic [STRB_W-1:0]  strb_q;
  logic [DATA_W-1:0]  data_q;
  logic               take_idle;
  logic               hit_reg;
  logic               hit_mbox;

  // --------------------------------------------------
  // accept rules in idle, by cycle type
  // --------------------------------------------------
  always_comb begin
    take_idle = 1'b0;
    case (rx_beat.user)
      // a write needs the register file to itself
      TUSER_WRITE:    take_idle = !local_busy;
      // completion only when a local read waits for it
      TUSER_READ_CPL: take_idle = cpl_wait;
      // accepted and dropped
      TUSER_STREAM,
      TUSER_READ_REQ: take_idle = 1'b1;
      default:        take_idle = 1'b0;
    endcase
  end

  // beat 2 of a write is always taken
  assign rx_ready = rx_valid &&
                    (((state == st_idle) && take_idle) || (state == st_beat2));

  // --------------------------------------------------
  // fsm and completion pulse
  // --------------------------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state     <= st_idle;
      cpl_valid <= 1'b0;
    end else begin
      cpl_valid <= rx_ready && (state == st_idle) && (rx_beat.user == TUSER_READ_CPL);
      case (state)
        st_idle: begin
          if (rx_ready && (rx_beat.user == TUSER_WRITE)) begin
            state <= st_beat2;
          end
        end
        st_beat2: begin
          if (rx_ready) begin
            state <= st_commit;
          end
        end
        // one cycle for the register write
        default: state <= st_idle;
      endcase
    end
  end

  // beat 1 gives address and strobes, beat 2 or a completion gives data
  always_ff @(posedge axis_clk) begin
    if (rx_ready && (state == st_idle) && (rx_beat.user == TUSER_WRITE)) begin
      addr_q <= rx_beat.data[RADDR_W-1:0];
      strb_q <= rx_beat.strb;
    end
    if (rx_ready && ((state == st_beat2) || (rx_beat.user == TUSER_READ_CPL))) begin
      data_q <= rx_beat.data;
    end
  end

  assign cpl_data    = data_q;
  assign remote_busy = (state != st_idle);

  // window hit on the latched beat 1 address
  assign hit_reg  = (addr_q[RADDR_W-1:8] == REMOTE_REG_PAGE);
  assign hit_mbox = (addr_q[RADDR_W-1:8] == REMOTE_MBOX_PAGE);

  assign rmt_wr.valid   = (state == st_commit) && (hit_reg || hit_mbox);
  assign rmt_wr.idx     = addr_q[MBOX_IDX_LSB +: MBOX_IDX_W];
  assign rmt_wr.reg_sel = hit_reg;
  assign rmt_wr.data    = data_q;
  assign rmt_wr.strb    = strb_q;

endmodule

//--- hw/aa_local_engine.sv
`timescale 1ns/1ps
// aa local engine
// axi-lite slave side of the bridge: serves the own register window
// on the spot, turns other writes into two write beats and other
// reads into a read request plus a wait for the completion beat
// a local mailbox write is stored first, then forwarded
module aa_local_engine
  import aa_pkg::*;
(
  input  logic               axis_clk,
  input  logic               axis_rst_n,
  input  logic               s_awvalid,
  input  logic [LADDR_W-1:0] s_awaddr,
  output logic               s_awready,
  input  logic               s_wvalid,
  input  logic [DATA_W-1:0]  s_wdata,
  input  logic [STRB_W-1:0]  s_wstrb,
  output logic               s_wready,
  input  logic               s_arvalid,
  input  logic [LADDR_W-1:0] s_araddr,
  output logic               s_arready,
  output logic [DATA_W-1:0]  s_rdata,
  output logic               s_rvalid,
  input  logic               s_rready,
  input  logic               local_enable,
  output stream_beat_t       tx_beat,
  output logic               tx_valid,
  input  logic               tx_ready,
  output reg_wr_t            lcl_wr,
  output logic [LADDR_W-1:0] lcl_rd_addr,
  input  logic [DATA_W-1:0]  lcl_rd_data,
  input  logic               remote_busy,
  input  logic               rx_write_pending,
  input  logic               cpl_valid,
  input  logic [DATA_W-1:0]  cpl_data,
  output logic               local_busy,
  output logic               cpl_wait
);

  typedef enum logic [3:0] {
    st_idle,
    st_write,
    st_read,
    st_fwd1,
    st_fwd2,
    st_rd_req,
    st_wait_cpl,
    st_done,
    st_mbox_fwd
  } state_t;

  state_t             state;
  state_t             state_nxt;
  logic [LADDR_W-1:0] addr_q;
  logic [DATA_W-1:0]  data_q;
  logic [STRB_W-1:0]  strb_q;
  logic               is_wr_q;
  logic               wr_req;
  logic               start;
  logic               hit_reg;
  logic               hit_mbox;

  // --------------------------------------------------
  // request capture
  // --------------------------------------------------
  // write needs aw and w together, write wins over read
  assign wr_req = s_awvalid && s_wvalid;
  // stay off the register file while the remote side is writing
  assign start  = (state == st_idle) && local_enable && !remote_busy &&
                  !rx_write_pending && (wr_req || s_arvalid);

  always_ff @(posedge axis_clk) begin
    if (start) begin
      addr_q <= wr_req ? s_awaddr : s_araddr;
      data_q <= s_wdata;
      strb_q <= s_wstrb;
    end
  end

  // window decode on the latched address
  assign hit_reg  = (addr_q[14:12] == LOCAL_WIN) && (addr_q[11:8] == LOCAL_REG_PAGE);
  assign hit_mbox = (addr_q[14:12] == LOCAL_WIN) && (addr_q[11:8] == LOCAL_MBOX_PAGE);

  // --------------------------------------------------
  // fsm
  // --------------------------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state   <= st_idle;
      is_wr_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (start) begin
        is_wr_q <= wr_req;
      end
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = wr_req ? st_write : st_read;
        end
      end
      // own window completes locally, mailbox forwards afterwards
      st_write:    state_nxt = (hit_reg || hit_mbox) ? st_done : st_fwd1;
      st_read:     state_nxt = (hit_reg || hit_mbox) ? st_done : st_rd_req;
      st_fwd1,
      st_mbox_fwd: state_nxt = tx_ready ? st_fwd2 : state;
      // mailbox forward ends after beat 2, its handshake is already done
      st_fwd2: begin
        if (tx_ready) begin
          state_nxt = hit_mbox ? st_idle : st_done;
        end
      end
      st_rd_req:   state_nxt = tx_ready ? st_wait_cpl : st_rd_req;
      st_wait_cpl: state_nxt = cpl_valid ? st_done : st_wait_cpl;
      st_done: begin
        if (is_wr_q) begin
          state_nxt = hit_mbox ? st_mbox_fwd : st_idle;
        end else if (s_rready) begin
          state_nxt = st_idle;
        end
      end
      default:     state_nxt = st_idle;
    endcase
  end

  // --------------------------------------------------
  // axi-lite side
  // --------------------------------------------------
  // aw and w ready pulse together for one cycle
  assign s_awready = (state == st_done) && is_wr_q;
  assign s_wready  = s_awready;
  assign s_arready = (state == st_read);
  // rvalid holds in done until rready
  assign s_rvalid  = (state == st_done) && !is_wr_q;
  assign s_rdata   = (hit_reg || hit_mbox) ? lcl_rd_data : cpl_data;

  assign local_busy  = (state != st_idle);
  assign cpl_wait    = (state == st_wait_cpl);
  assign lcl_rd_addr = addr_q;

  // register file write lands on the aw/w handshake
  assign lcl_wr.valid   = s_awready && (hit_reg || hit_mbox);
  assign lcl_wr.idx     = addr_q[MBOX_IDX_LSB +: MBOX_IDX_W];
  assign lcl_wr.reg_sel = hit_reg;
  assign lcl_wr.data    = data_q;
  assign lcl_wr.strb    = strb_q;

  // --------------------------------------------------
  // stream beats
  // --------------------------------------------------
  // built from latched state only, so a stalled beat stays put
  assign tx_valid = (state == st_fwd1) || (state == st_mbox_fwd) ||
                    (state == st_fwd2) || (state == st_rd_req);

  always_comb begin
    tx_beat = '0;
    case (state)
      st_fwd1,
      st_mbox_fwd: begin
        // beat 1: strobes on top of the 28-bit address
        tx_beat.data = {strb_q, {(RADDR_W - LADDR_W){1'b0}}, addr_q};
        tx_beat.strb = strb_q;
        tx_beat.user = TUSER_WRITE;
      end
      st_fwd2: begin
        tx_beat.data = data_q;
        tx_beat.strb = strb_q;
        tx_beat.user = TUSER_WRITE;
      end
      st_rd_req: begin
        tx_beat.data = {{(DATA_W - LADDR_W){1'b0}}, addr_q};
        tx_beat.strb = '1;
        tx_beat.user = TUSER_READ_REQ;
      end
      default: tx_beat = '0;
    endcase
  end

endmodule

//--- hw/aa_bridge_top.sv
`timescale 1ns/1ps
// aa bridge top level
// joins a local axi-lite slave to a pair of axi-stream ports
// local engine converts axi-lite accesses into stream beats,
// remote engine collects incoming writes and read completions,
// both share the mailbox and interrupt register block
module aa_bridge_top
  import aa_pkg::*;
(
  input  logic               axis_clk,
  input  logic               axis_rst_n,
  // axi-lite slave
  input  logic               s_awvalid,
  input  logic [LADDR_W-1:0] s_awaddr,
  output logic               s_awready,
  input  logic               s_wvalid,
  input  logic [DATA_W-1:0]  s_wdata,
  input  logic [STRB_W-1:0]  s_wstrb,
  output logic               s_wready,
  input  logic               s_arvalid,
  input  logic [LADDR_W-1:0] s_araddr,
  output logic               s_arready,
  output logic [DATA_W-1:0]  s_rdata,
  output logic               s_rvalid,
  input  logic               s_rready,
  // stream in
  input  stream_beat_t       rx_beat,
  input  logic               rx_valid,
  output logic               rx_ready,
  // stream out
  output stream_beat_t       tx_beat,
  output logic               tx_valid,
  input  logic               tx_ready,
  // misc
  input  logic               local_enable,
  output logic               mb_irq
);

  reg_wr_t            lcl_wr;
  reg_wr_t            rmt_wr;
  logic [LADDR_W-1:0] lcl_rd_addr;
  logic [DATA_W-1:0]  lcl_rd_data;
  logic               local_busy;
  logic               remote_busy;
  logic               cpl_wait;
  logic               cpl_valid;
  logic [DATA_W-1:0]  cpl_data;
  logic               rx_write_pending;

  // an incoming write beat holds off the local engine in idle
  assign rx_write_pending = rx_valid && (rx_beat.user == TUSER_WRITE);

  aa_local_engine aa_local_engine_i (
    .axis_clk         (axis_clk),
    .axis_rst_n       (axis_rst_n),
    .s_awvalid        (s_awvalid),
    .s_awaddr         (s_awaddr),
    .s_awready        (s_awready),
    .s_wvalid         (s_wvalid),
    .s_wdata          (s_wdata),
    .s_wstrb          (s_wstrb),
    .s_wready         (s_wready),
    .s_arvalid        (s_arvalid),
    .s_araddr         (s_araddr),
    .s_arready        (s_arready),
    .s_rdata          (s_rdata),
    .s_rvalid         (s_rvalid),
    .s_rready         (s_rready),
    .local_enable     (local_enable),
    .tx_beat          (tx_beat),
    .tx_valid         (tx_valid),
    .tx_ready         (tx_ready),
    .lcl_wr           (lcl_wr),
    .lcl_rd_addr      (lcl_rd_addr),
    .lcl_rd_data      (lcl_rd_data),
    .remote_busy      (remote_busy),
    .rx_write_pending (rx_write_pending),
    .cpl_valid        (cpl_valid),
    .cpl_data         (cpl_data),
    .local_busy       (local_busy),
    .cpl_wait         (cpl_wait)
  );

  aa_remote_engine aa_remote_engine_i (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .rx_beat     (rx_beat),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .local_busy  (local_busy),
    .cpl_wait    (cpl_wait),
    .rmt_wr      (rmt_wr),
    .remote_busy (remote_busy),
    .cpl_valid   (cpl_valid),
    .cpl_data    (cpl_data)
  );

  aa_mailbox_regs aa_mailbox_regs_i (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .lcl_wr      (lcl_wr),
    .rmt_wr      (rmt_wr),
    .lcl_rd_addr (lcl_rd_addr),
    .lcl_rd_data (lcl_rd_data),
    .mb_irq      (mb_irq)
  );

endmodule

//--- dv/aa_tb_sva.sv
`timescale 1ns/1ps
// aa bridge protocol checks
// bound into the bridge top level: stream output hold under
// back-pressure, quiet outputs in reset, and the irq output
// against enable and status as software reads them
module aa_tb_sva
  import aa_pkg::*;
(
  input logic               axis_clk,
  input logic               axis_rst_n,
  input logic               s_awvalid,
  input logic [LADDR_W-1:0] s_awaddr,
  input logic               s_awready,
  input logic [DATA_W-1:0]  s_wdata,
  input logic [STRB_W-1:0]  s_wstrb,
  input logic [DATA_W-1:0]  s_rdata,
  input logic               s_rvalid,
  input logic               s_rready,
  input logic [LADDR_W-1:0] lcl_rd_addr,
  input stream_beat_t       tx_beat,
  input logic               tx_valid,
  input logic               tx_ready,
  input logic               mb_irq
);

  int   fail_cnt = 0;
  logic en_shadow;
  logic en_wr;
  logic en_rd;
  logic sts_rd;

  // interrupt register page of the local window
  function automatic logic reg_page(input logic [LADDR_W-1:0] addr);
    return (addr[14:12] == LOCAL_WIN) && (addr[11:8] == LOCAL_REG_PAGE);
  endfunction

  // --------------------------------------------------
  // enable as seen from the axi-lite side
  // --------------------------------------------------
  assign en_wr  = s_awvalid && s_awready && reg_page(s_awaddr) &&
                  !s_awaddr[REG_SEL_BIT] && s_wstrb[0];
  assign en_rd  = s_rvalid && s_rready && reg_page(lcl_rd_addr) && !lcl_rd_addr[REG_SEL_BIT];
  assign sts_rd = s_rvalid && s_rready && reg_page(lcl_rd_addr) && lcl_rd_addr[REG_SEL_BIT];

  // remote writes into the register page are not followed here
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      en_shadow <= 1'b0;
    end else if (en_wr) begin
      en_shadow <= s_wdata[0];
    end else if (en_rd) begin
      en_shadow <= s_rdata[0];
    end
  end

  // --------------------------------------------------
  // properties
  // --------------------------------------------------
  // a stalled beat waits in place
  tx_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
    else begin
      $error("stream output beat changed or dropped while stalled");
      fail_cnt++;
    end

  tx_quiet_in_reset: assert property (@(posedge axis_clk)
      !axis_rst_n |-> !tx_valid && !mb_irq)
    else begin
      $error("stream valid or irq high during reset");
      fail_cnt++;
    end

  // status readback cycle: irq must be status and enable
  irq_matches: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
      sts_rd |-> (mb_irq == (s_rdata[0] && en_shadow)))
    else begin
      $error("irq does not match status and enable at status readback");
      fail_cnt++;
    end

endmodule

//--- dv/aa_tb.sv
`timescale 1ns/1ps
// aa bridge testbench
// runs the axi-lite slave and both stream ports through local register
// and mailbox accesses, forwarded writes and reads, remote writes and
// discarded remote beats; a mailbox model here gives expected values
module aa_tb
  import aa_pkg::*;
();

  localparam int SEED = 60;
  // six tests take a few hundred cycles, leave a wide margin
  localparam int MAX_CYCLES = 4000;
  localparam logic [LADDR_W-1:0] MBOX_BASE = 15'h2000;
  localparam logic [LADDR_W-1:0] IRQ_EN    = 15'h2100;
  localparam logic [LADDR_W-1:0] IRQ_STS   = 15'h2104;

  logic               axis_clk = 1'b0;
  logic               axis_rst_n;
  logic               s_awvalid;
  logic [LADDR_W-1:0] s_awaddr;
  logic               s_awready;
  logic               s_wvalid;
  logic [DATA_W-1:0]  s_wdata;
  logic [STRB_W-1:0]  s_wstrb;
  logic               s_wready;
  logic               s_arvalid;
  logic [LADDR_W-1:0] s_araddr;
  logic               s_arready;
  logic [DATA_W-1:0]  s_rdata;
  logic               s_rvalid;
  logic               s_rready;
  stream_beat_t       rx_beat;
  logic               rx_valid;
  logic               rx_ready;
  stream_beat_t       tx_beat;
  logic               tx_valid;
  logic               tx_ready;
  logic               local_enable;
  logic               mb_irq;

  stream_beat_t       tx_q[$];
  logic [DATA_W-1:0]  exp_mbox [MBOX_WORDS];
  int                 errors;
  int                 test_start;
  int                 tests_run;
  int                 cycles;

  aa_bridge_top aa_bridge_top_i (.*);

  bind aa_bridge_top aa_tb_sva aa_tb_sva_i (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .s_awvalid   (s_awvalid),
    .s_awaddr    (s_awaddr),
    .s_awready   (s_awready),
    .s_wdata     (s_wdata),
    .s_wstrb     (s_wstrb),
    .s_rdata     (s_rdata),
    .s_rvalid    (s_rvalid),
    .s_rready    (s_rready),
    .lcl_rd_addr (lcl_rd_addr),
    .tx_beat     (tx_beat),
    .tx_valid    (tx_valid),
    .tx_ready    (tx_ready),
    .mb_irq      (mb_irq)
  );

  always #5 axis_clk = ~axis_clk;

  // random back-pressure, ready about three cycles in four
  initial begin
    tx_ready = 1'b0;
    forever begin
      @(posedge axis_clk);
      tx_ready <= (($urandom % 4) != 0);
    end
  end

  // taken beats, seen half a cycle before their edge
  always @(negedge axis_clk) begin
    if (tx_valid && tx_ready) begin
      tx_q.push_back(tx_beat);
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge axis_clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------
  // expected values and checks
  // --------------------------------------------------
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] new_word, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] word;
    word = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        word[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return word;
  endfunction

  // write beat 1: strobes above the zero-extended 28-bit address
  function automatic logic [DATA_W-1:0] addr_beat(input logic [STRB_W-1:0] strb,
      input logic [LADDR_W-1:0] addr);
    return {strb, RADDR_W'(addr)};
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                             input logic [DATA_W-1:0] expected);
    assert (actual === expected) else begin
      $display("FAIL %0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_start) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic expect_tx(input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                           input logic [USER_W-1:0] user, input string name);
    stream_beat_t beat;
    while (tx_q.size() == 0) begin
      @(negedge axis_clk);
    end
    beat = tx_q.pop_front();
    check_value({name, " tx_beat.data"}, beat.data, data);
    check_value({name, " tx_beat.strb"}, 32'(beat.strb), 32'(strb));
    check_value({name, " tx_beat.user"}, 32'(beat.user), 32'(user));
  endtask

  // --------------------------------------------------
  // bus drivers
  // --------------------------------------------------
  task automatic send_rx(input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                         input logic [USER_W-1:0] user);
    @(posedge axis_clk);
    rx_valid <= 1'b1;
    rx_beat  <= '{data: data, strb: strb, user: user};
    do begin
      @(negedge axis_clk);
    end while (!rx_ready);
    @(posedge axis_clk);
    rx_valid <= 1'b0;
  endtask

  task automatic remote_write(input logic [RADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb);
    send_rx({strb, addr}, strb, TUSER_WRITE);
    send_rx(data, strb, TUSER_WRITE);
  endtask

  // beats_at_hs counts output beats already taken when aw/w ready shows
  task automatic axil_write(input logic [LADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, output int beats_at_hs);
    @(posedge axis_clk);
    s_awvalid <= 1'b1;
    s_awaddr  <= addr;
    s_wvalid  <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= strb;
    do begin
      @(negedge axis_clk);
    end while (!s_awready);
    // w ready pulses in the same cycle as aw ready
    check_value("s_wready", 32'(s_wready), 32'd1);
    beats_at_hs = tx_q.size();
    @(posedge axis_clk);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
  endtask

  // a forwarded read checks its request beat and answers with cpl
  task automatic axil_read(input logic [LADDR_W-1:0] addr, input logic remote,
                           input logic [DATA_W-1:0] cpl, output logic [DATA_W-1:0] data);
    @(posedge axis_clk);
    s_arvalid <= 1'b1;
    s_araddr  <= addr;
    do begin
      @(negedge axis_clk);
    end while (!s_arready);
    @(posedge axis_clk);
    s_arvalid <= 1'b0;
    if (remote) begin
      expect_tx(32'(addr), 4'hf, TUSER_READ_REQ, "read request");
      send_rx(cpl, 4'hf, TUSER_READ_CPL);
    end
    do begin
      @(negedge axis_clk);
    end while (!s_rvalid);
    data = s_rdata;
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial begin
    logic [DATA_W-1:0]  rd;
    logic [DATA_W-1:0]  wdata;
    logic [STRB_W-1:0]  wstrb;
    logic [LADDR_W-1:0] addr;
    int                 idx;
    int                 beats;
    void'($urandom(SEED));
    errors       = 0;
    test_start   = 0;
    tests_run    = 0;
    axis_rst_n   = 1'b0;
    s_awvalid    = 1'b0;
    s_awaddr     = '0;
    s_wvalid     = 1'b0;
    s_wdata      = '0;
    s_wstrb      = '0;
    s_arvalid    = 1'b0;
    s_araddr     = '0;
    s_rready     = 1'b1;
    rx_beat      = '0;
    rx_valid     = 1'b0;
    local_enable = 1'b1;
    repeat (5) @(posedge axis_clk);
    axis_rst_n <= 1'b1;
    @(negedge axis_clk);

    check_value("tx_valid", 32'(tx_valid), 32'd0);
    check_value("rx_ready", 32'(rx_ready), 32'd0);
    check_value("s_rvalid", 32'(s_rvalid), 32'd0);
    check_value("s_awready", 32'(s_awready), 32'd0);
    check_value("mb_irq", 32'(mb_irq), 32'd0);
    finish_test("reset values");

    // full words first, then strobed merges
    for (int i = 0; i < MBOX_WORDS; i++) begin
      wdata = $urandom;
      addr  = MBOX_BASE + LADDR_W'(4 * i);
      axil_write(addr, wdata, 4'hf, beats);
      exp_mbox[i] = wdata;
      expect_tx(addr_beat(4'hf, addr), 4'hf, TUSER_WRITE, "mailbox beat 1");
      expect_tx(wdata, 4'hf, TUSER_WRITE, "mailbox beat 2");
    end
    for (int i = 0; i < 4; i++) begin
      idx   = int'($urandom % MBOX_WORDS);
      wdata = $urandom;
      wstrb = STRB_W'($urandom);
      addr  = MBOX_BASE + LADDR_W'(4 * idx);
      axil_write(addr, wdata, wstrb, beats);
      exp_mbox[idx] = merge_bytes(exp_mbox[idx], wdata, wstrb);
      expect_tx(addr_beat(wstrb, addr), wstrb, TUSER_WRITE, "mailbox beat 1");
      expect_tx(wdata, wstrb, TUSER_WRITE, "mailbox beat 2");
    end
    for (int i = 0; i < MBOX_WORDS; i++) begin
      axil_read(MBOX_BASE + LADDR_W'(4 * i), 1'b0, '0, rd);
      check_value($sformatf("mbox[%0d]", i), rd, exp_mbox[i]);
    end
    axil_write(IRQ_EN, 32'h1, 4'h1, beats);
    axil_read(IRQ_EN, 1'b0, '0, rd);
    check_value("irq enable", rd, 32'h1);
    axil_write(IRQ_EN, 32'h0, 4'h1, beats);
    axil_read(IRQ_EN, 1'b0, '0, rd);
    check_value("irq enable", rd, 32'h0);
    finish_test("local mailbox and enable");

    // page 4 is outside the window
    for (int i = 0; i < 4; i++) begin
      addr  = (LADDR_W'($urandom) & 15'h0ffc) | 15'h4000;
      wdata = $urandom;
      wstrb = STRB_W'($urandom);
      axil_write(addr, wdata, wstrb, beats);
      check_value("beats before s_awready", 32'(beats), 32'd2);
      expect_tx(addr_beat(wstrb, addr), wstrb, TUSER_WRITE, "forward beat 1");
      expect_tx(wdata, wstrb, TUSER_WRITE, "forward beat 2");
    end
    finish_test("forwarded write");

    for (int i = 0; i < 3; i++) begin
      addr  = (LADDR_W'($urandom) & 15'h0ffc) | 15'h4000;
      wdata = $urandom;
      axil_read(addr, 1'b1, wdata, rd);
      check_value("s_rdata", rd, wdata);
    end
    finish_test("forwarded read");

    // remote write to word 6 raises status, irq waits for enable
    wdata = $urandom;
    remote_write({REMOTE_MBOX_PAGE, 8'h18}, wdata, 4'hf);
    exp_mbox[6] = wdata;
    axil_read(MBOX_BASE + 15'h18, 1'b0, '0, rd);
    check_value("mbox[6]", rd, exp_mbox[6]);
    axil_read(IRQ_STS, 1'b0, '0, rd);
    check_value("irq status", rd, 32'h1);
    check_value("mb_irq", 32'(mb_irq), 32'd0);
    axil_write(IRQ_EN, 32'h1, 4'h1, beats);
    @(negedge axis_clk);
    check_value("mb_irq", 32'(mb_irq), 32'd1);
    axil_write(IRQ_STS, 32'h1, 4'h1, beats);
    @(negedge axis_clk);
    check_value("mb_irq", 32'(mb_irq), 32'd0);
    axil_read(IRQ_STS, 1'b0, '0, rd);
    check_value("irq status", rd, 32'h0);
    finish_test("remote mailbox write and irq");

    send_rx($urandom, 4'hf, TUSER_STREAM);
    send_rx($urandom, 4'hf, TUSER_READ_REQ);
    remote_write({20'h00030, 8'h08}, $urandom, 4'hf);
    for (int i = 0; i < MBOX_WORDS; i++) begin
      axil_read(MBOX_BASE + LADDR_W'(4 * i), 1'b0, '0, rd);
      check_value($sformatf("mbox[%0d]", i), rd, exp_mbox[i]);
    end
    axil_read(IRQ_STS, 1'b0, '0, rd);
    check_value("irq status", rd, 32'h0);
    check_value("stray tx beats", 32'(tx_q.size()), 32'd0);
    finish_test("discarded remote beats");

    errors += aa_bridge_top_i.aa_tb_sva_i.fail_cnt;
    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
hw/aa_pkg.sv
hw/aa_mailbox_regs.sv
hw/aa_remote_engine.sv
hw/aa_local_engine.sv
hw/aa_bridge_top.sv
dv/aa_tb_sva.sv
dv/aa_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the aa bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module aa_tb -f filelist.f

# keep going after an assertion error so the testbench reaches its verdict
out="$(./obj_dir/Vaa_tb +verilator+error+limit+100 || true)"
echo "$out"

if grep -qx "TEST OK" <<< "$out"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
